//--- cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address split into tag, set index and byte offset within the line
`define CACHE_TAG_W     9
`define CACHE_INDEX_W   3
`define CACHE_OFFSET_W  4

// number of sets, one per index value
`define CACHE_SETS      8

// CPU word and physical memory line
`define CACHE_WORD_W    16
`define CACHE_LINE_W    128   // eight words per line

`endif

//--- cache_types_pkg.sv
`include "cache_defines.svh"

package cache_types_pkg;

    typedef logic [`CACHE_WORD_W-1:0]   lc3b_word;
    typedef logic [`CACHE_TAG_W-1:0]    lc3b_cache_tag;
    typedef logic [`CACHE_INDEX_W-1:0]  lc3b_cache_index;
    typedef logic [`CACHE_OFFSET_W-1:0] lc3b_cache_offset;
    typedef logic [`CACHE_LINE_W-1:0]   lc3b_cache_line;
    typedef logic [`CACHE_WORD_W-1:0]   lc3b_pmem_addr;   // line aligned, low offset bits zero
    typedef logic [`CACHE_SETS-1:0]     cache_set_bits_t; // one bit per set

    // how a byte address splits up
    typedef struct packed {
        lc3b_cache_tag    tag;
        lc3b_cache_index  index;
        lc3b_cache_offset offset;
    } cache_addr_t;

    typedef struct packed {
        logic hit;          // a valid way matches the request tag
        logic hit_way;
        logic victim_way;   // invalid way first, else the LRU way
        logic victim_dirty;
    } cache_status_t;

    typedef struct packed {
        logic write_hit;    // merge the CPU word into the hit way
        logic install;      // load the fetched line into the victim way
        logic touch_lru;
        logic wb_addr_sel;  // victim tag onto the physical address
    } cache_ctrl_t;

endpackage

//--- cache_array.sv
`timescale 1ns/1ps

// one entry per set, read combinationally by index and written on the clock edge
module cache_array import cache_types_pkg::*; #(
    parameter type entry_t = lc3b_cache_line
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  lc3b_cache_index index,
    input  entry_t          in,
    output entry_t          out
);

    localparam int SETS = $bits(cache_set_bits_t);

    entry_t data [SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SETS; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[index] <= in;
        end
    end

    // the read follows the index in the same cycle so hits can answer at once
    assign out = data[index];

endmodule

//--- cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath import cache_types_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  cache_ctrl_t    ctrl,
    input  lc3b_word       mem_address,
    input  lc3b_word       mem_wdata,
    input  lc3b_cache_line pmem_rdata,
    output cache_status_t  status,
    output lc3b_word       mem_rdata,
    output lc3b_pmem_addr  pmem_address,
    output lc3b_cache_line pmem_wdata
);

    localparam int WORD_W = $bits(lc3b_word);

    cache_addr_t     addr;
    cache_addr_t     pmem_addr_s;
    logic [2:0]      word_sel;
    lc3b_cache_tag   tag_out [2];
    lc3b_cache_line  line_out [2];
    lc3b_cache_line  line_in;
    lc3b_cache_line  merged_line;
    lc3b_cache_line  fill_line;
    logic [1:0]      way_hit;
    logic [1:0]      tag_load;
    logic [1:0]      line_load;
    logic            hit_way;
    logic            victim_way;

    cache_set_bits_t [1:0] valid;
    cache_set_bits_t [1:0] dirty;
    cache_set_bits_t       lru;   // per set, the way used least recently

    assign addr     = mem_address;
    assign word_sel = addr.offset[3:1]; // bit 0 is the byte within the word

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_array #(.entry_t(lc3b_cache_tag)) u_tag (
            .clk   (clk),
            .rst   (rst),
            .load  (tag_load[w]),
            .index (addr.index),
            .in    (addr.tag),
            .out   (tag_out[w])
        );

        cache_array #(.entry_t(lc3b_cache_line)) u_line (
            .clk   (clk),
            .rst   (rst),
            .load  (line_load[w]),
            .index (addr.index),
            .in    (line_in),
            .out   (line_out[w])
        );

        assign way_hit[w]   = valid[w][addr.index] && (tag_out[w] == addr.tag);
        assign tag_load[w]  = ctrl.install && (victim_way == 1'(w));
        assign line_load[w] = tag_load[w] || (ctrl.write_hit && (hit_way == 1'(w)));
    end

    assign hit_way = way_hit[1];

    // an empty way is filled before anything valid gets evicted
    always_comb begin
        if (!valid[0][addr.index]) begin
            victim_way = 1'b0;
        end else if (!valid[1][addr.index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[addr.index];
        end
    end

    assign status.hit          = |way_hit;
    assign status.hit_way      = hit_way;
    assign status.victim_way   = victim_way;
    assign status.victim_dirty = valid[victim_way][addr.index] && dirty[victim_way][addr.index];

    always_comb begin
        merged_line = line_out[hit_way];
        merged_line[word_sel*WORD_W +: WORD_W] = mem_wdata;
    end

    // memory data is only valid with pmem_resp, the install cycle follows one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_line <= '0;
        end else begin
            fill_line <= pmem_rdata;
        end
    end

    assign line_in   = ctrl.install ? fill_line : merged_line;
    assign mem_rdata = line_out[hit_way][word_sel*WORD_W +: WORD_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (ctrl.install) begin
                valid[victim_way][addr.index] <= 1'b1;
                dirty[victim_way][addr.index] <= 1'b0; // fresh copy matches memory
            end
            if (ctrl.write_hit) begin
                dirty[hit_way][addr.index] <= 1'b1;
            end
            if (ctrl.touch_lru) begin
                lru[addr.index] <= ~hit_way;   // the other way becomes least recent
            end
        end
    end

    // write-back goes to the victim's own line, fetches to the requested one
    always_comb begin
        pmem_addr_s.tag    = ctrl.wb_addr_sel ? tag_out[victim_way] : addr.tag;
        pmem_addr_s.index  = addr.index;
        pmem_addr_s.offset = '0;
    end

    assign pmem_address = pmem_addr_s;
    assign pmem_wdata   = line_out[victim_way];

endmodule

//--- cache_control.sv
`timescale 1ns/1ps

module cache_control import cache_types_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          mem_read,
    input  logic          mem_write,
    input  logic          pmem_resp,
    input  cache_status_t status,
    output logic          mem_resp,
    output logic          pmem_read,
    output logic          pmem_write,
    output cache_ctrl_t   ctrl
);

    typedef enum logic [1:0] {
        s_compare,
        s_write_back,
        s_fetch,
        s_install
    } state_t;

    state_t state;
    state_t next_state;
    logic   request;

    assign request = mem_read || mem_write;

    always_comb begin
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        ctrl       = '0;

        case (state)
            s_compare: begin
                if (request && status.hit) begin
                    mem_resp       = 1'b1;
                    ctrl.touch_lru = 1'b1;
                    ctrl.write_hit = mem_write;  // reads only refresh the LRU bit
                end
            end

            s_write_back: begin
                pmem_write       = 1'b1;
                ctrl.wb_addr_sel = 1'b1;
            end

            s_fetch: begin
                pmem_read = 1'b1;
            end

            s_install: begin
                ctrl.install = 1'b1;
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_comb begin
        next_state = state;

        case (state)
            s_compare: begin
                // a dirty victim must reach memory before its line is reused
                if (request && !status.hit) begin
                    next_state = status.victim_dirty ? s_write_back : s_fetch;
                end
            end

            s_write_back: begin
                if (pmem_resp) begin
                    next_state = s_fetch;
                end
            end

            s_fetch: begin
                if (pmem_resp) begin
                    next_state = s_install;
                end
            end

            s_install: begin
                next_state = s_compare; // the access is retried and now hits
            end

            default: begin
                next_state = s_compare;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_compare;
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- cache.sv
`timescale 1ns/1ps

module cache import cache_types_pkg::*; (
    input  logic           clk,
    input  logic           rst,

    // CPU side
    input  logic           mem_read,
    input  logic           mem_write,
    input  lc3b_word       mem_address,
    input  lc3b_word       mem_wdata,
    output logic           mem_resp,
    output lc3b_word       mem_rdata,

    // physical memory side, one whole line per transfer
    input  logic           pmem_resp,
    input  lc3b_cache_line pmem_rdata,
    output logic           pmem_read,
    output logic           pmem_write,
    output lc3b_pmem_addr  pmem_address,
    output lc3b_cache_line pmem_wdata
);

    cache_ctrl_t   ctrl;
    cache_status_t status;

    cache_control u_control (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .status     (status),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .ctrl       (ctrl)
    );

    cache_datapath u_datapath (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_rdata   (pmem_rdata),
        .status       (status),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

// free running clock plus a synchronous reset held for a fixed number of cycles
module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // released between edges like every other DUT input
    end

endmodule

//--- cache_tb.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_tb import cache_types_pkg::*; ();

    localparam int CLK_PERIOD_NS = 10;
    localparam int RESET_CYCLES  = 10;
    localparam int RANDOM_OPS    = 300;
    localparam int DIRECTED_OPS  = 8;
    localparam int MISS_CYCLES   = 2 * 9 + 2;   // two transfers of up to 9 cycles, install, compare
    localparam int WATCHDOG_NS   = 2 * ((RANDOM_OPS + DIRECTED_OPS) * (MISS_CYCLES + 2)
                                        + RESET_CYCLES) * CLK_PERIOD_NS;
    localparam int LINE_WORDS    = `CACHE_LINE_W / `CACHE_WORD_W;
    localparam lc3b_word FILL_KEY = 16'h5a3c;
    localparam lc3b_cache_tag TAG_POOL [4] = '{9'h000, 9'h0a5, 9'h13c, 9'h1ff};

    logic clk, rst, mem_read, mem_write, mem_resp, pmem_resp, pmem_read, pmem_write;
    lc3b_word mem_address, mem_wdata, mem_rdata;
    lc3b_pmem_addr pmem_address;
    lc3b_cache_line pmem_rdata, pmem_wdata;

    logic [31:0] lfsr = 32'hddd6_b9f8;
    lc3b_cache_line phys_mem [logic [11:0]];   // keyed by line number
    lc3b_word model_mem [lc3b_word];           // words written by the CPU so far
    lc3b_cache_tag m_tag [2][`CACHE_SETS];
    logic m_valid [2][`CACHE_SETS];
    logic m_dirty [2][`CACHE_SETS];
    logic m_lru [`CACHE_SETS];
    logic ev_write [$];                        // physical transfers of the current access
    lc3b_word ev_addr [$];
    lc3b_cache_line ev_data [$];
    int pmem_reads = 0, pmem_writes = 0, checks = 0, errors = 0;
    int test_checks, test_errors;
    string test_name;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    cache u_dut (
        .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
        .mem_address(mem_address), .mem_wdata(mem_wdata), .mem_resp(mem_resp),
        .mem_rdata(mem_rdata), .pmem_resp(pmem_resp), .pmem_rdata(pmem_rdata),
        .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata)
    );

    // taps 32, 22, 2 and 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_step()};
        return r;
    endfunction

    // untouched memory holds each word's own byte address scrambled by a key
    function automatic lc3b_cache_line init_line(input logic [11:0] line_no);
        lc3b_cache_line line;
        for (int w = 0; w < LINE_WORDS; w++) line[w*16 +: 16] = {line_no, 3'(w), 1'b0} ^ FILL_KEY;
        return line;
    endfunction

    function automatic lc3b_word model_word(input lc3b_word addr);
        return model_mem.exists(addr) ? model_mem[addr] : addr ^ FILL_KEY;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        test_checks++;
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    // runs one CPU access, predicting its outcome from the model first
    task automatic access(input string name, input lc3b_word addr, input logic is_write,
                          input lc3b_word wdata, output logic hit_seen);
        lc3b_cache_index idx;
        lc3b_cache_tag tag;
        logic exp_hit, exp_wb, way, pmem_seen;
        lc3b_word wb_addr, exp_rdata, got_rdata;
        lc3b_cache_line wb_line;
        int cycles, last;
        idx = addr[6:4];
        tag = addr[15:7];
        exp_hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                exp_hit = 1'b1;
                way = 1'(w);
            end
        end
        exp_wb = 1'b0;
        wb_addr = '0;
        wb_line = '0;
        if (!exp_hit) begin
            way = !m_valid[0][idx] ? 1'b0 : (!m_valid[1][idx] ? 1'b1 : m_lru[idx]);
            exp_wb = m_valid[way][idx] && m_dirty[way][idx];
            wb_addr = {m_tag[way][idx], idx, 4'h0};
            for (int w = 0; w < LINE_WORDS; w++)
                wb_line[w*16 +: 16] = model_word({wb_addr[15:4], 3'(w), 1'b0});
            m_tag[way][idx] = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        m_lru[idx] = ~way;
        if (is_write) begin
            m_dirty[way][idx] = 1'b1;
            model_mem[addr] = wdata;
        end
        exp_rdata = model_word(addr);

        ev_write.delete();
        ev_addr.delete();
        ev_data.delete();
        @(negedge clk);
        mem_address = addr;
        mem_wdata = wdata;
        mem_read = !is_write;
        mem_write = is_write;
        cycles = 0;
        pmem_seen = 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            if (pmem_read || pmem_write) pmem_seen = 1'b1;
        end while (!mem_resp);
        got_rdata = mem_rdata;
        @(negedge clk);
        mem_read = 1'b0;
        mem_write = 1'b0;

        hit_seen = (cycles == 1) && (ev_write.size() == 0);
        last = ev_write.size() - 1;
        if (exp_hit) begin
            check_value({name, " hit latency"}, 128'(1), 128'(cycles));
            check_value({name, " pmem request on hit"}, 128'(0), 128'(pmem_seen));
        end else begin
            check_value({name, " transfers"}, 128'(exp_wb ? 2 : 1), 128'(ev_write.size()));
            if (ev_write.size() == (exp_wb ? 2 : 1)) begin
                if (exp_wb) begin
                    check_value({name, " write-back first"}, 128'(1), 128'(ev_write[0]));
                    check_value({name, " write-back address"}, 128'(wb_addr), 128'(ev_addr[0]));
                    check_value({name, " write-back data"}, wb_line, ev_data[0]);
                end
                check_value({name, " fetch kind"}, 128'(0), 128'(ev_write[last]));
                check_value({name, " fetch address"}, 128'({addr[15:4], 4'h0}),
                            128'(ev_addr[last]));
            end
        end
        if (!is_write) check_value({name, " rdata"}, 128'(exp_rdata), 128'(got_rdata));
    endtask

    // physical memory answers each held request once after 1 to 8 cycles
    initial begin
        pmem_resp = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            pmem_resp = 1'b0;
            pmem_rdata = '0;    // read data is only driven alongside the response pulse
            if (!rst && (pmem_read || pmem_write)) begin
                repeat (rand_bits(3)) @(negedge clk);
                if (pmem_write) begin
                    phys_mem[pmem_address[15:4]] = pmem_wdata;
                    pmem_writes++;
                end else begin
                    pmem_rdata = phys_mem.exists(pmem_address[15:4]) ?
                                 phys_mem[pmem_address[15:4]] : init_line(pmem_address[15:4]);
                    pmem_reads++;
                end
                ev_write.push_back(pmem_write);
                ev_addr.push_back(pmem_address);
                ev_data.push_back(pmem_wdata);
                pmem_resp = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: a response never came within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        lc3b_word addr, wdata;
        logic is_write, hit_seen;
        int writes_before;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_dirty[0][s] = 1'b0;
            m_dirty[1][s] = 1'b0;
            m_lru[s] = 1'b0;
            m_tag[0][s] = '0;
            m_tag[1][s] = '0;
        end
        @(negedge rst);

        begin_test("reset_state");
        @(posedge clk);
        check_value("reset_state mem_resp", 128'(0), 128'(mem_resp));
        check_value("reset_state pmem_read", 128'(0), 128'(pmem_read));
        check_value("reset_state pmem_write", 128'(0), 128'(pmem_write));
        writes_before = pmem_writes;
        access("reset_state first", {9'h0a5, 3'd2, 4'h6}, 1'b0, 16'h0000, hit_seen);
        check_value("reset_state first hit", 128'(0), 128'(hit_seen));
        check_value("reset_state write-backs", 128'(0), 128'(pmem_writes - writes_before));
        end_test();

        // lines A, B and C share set 5; both A and B are made dirty
        begin_test("lru_replace");
        access("lru_replace write A", {9'h011, 3'd5, 4'h2}, 1'b1, 16'h1a1a, hit_seen);
        access("lru_replace write B", {9'h022, 3'd5, 4'h4}, 1'b1, 16'h2b2b, hit_seen);
        access("lru_replace read A", {9'h011, 3'd5, 4'h2}, 1'b0, 16'h0000, hit_seen);
        check_value("lru_replace A again hit", 128'(1), 128'(hit_seen));
        access("lru_replace read C", {9'h033, 3'd5, 4'h0}, 1'b0, 16'h0000, hit_seen);
        check_value("lru_replace evicted line", 128'({9'h022, 3'd5, 4'h0}),
                    128'((ev_addr.size() == 2) ? ev_addr[0] : 16'hffff));
        access("lru_replace read A", {9'h011, 3'd5, 4'he}, 1'b0, 16'h0000, hit_seen);
        check_value("lru_replace A kept", 128'(1), 128'(hit_seen));
        access("lru_replace read B", {9'h022, 3'd5, 4'h4}, 1'b0, 16'h0000, hit_seen);
        check_value("lru_replace B gone", 128'(0), 128'(hit_seen));
        end_test();

        begin_test("random_traffic");
        for (int i = 0; i < RANDOM_OPS; i++) begin
            addr = {TAG_POOL[2'(rand_bits(2))], 3'(rand_bits(3)), 3'(rand_bits(3)), 1'b0};
            is_write = 1'(rand_bits(1));
            wdata = 16'(rand_bits(16));
            access($sformatf("random_traffic op %0d", i), addr, is_write, wdata, hit_seen);
        end
        end_test();

        $display("summary: %0d checks, %0d errors, %0d line reads, %0d line writes",
                 checks, errors, pmem_reads, pmem_writes);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
cache_types_pkg.sv
cache_array.sv
cache_datapath.sv
cache_control.sv
cache.sv
tb_clock_gen.sv
cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the cache testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module cache_tb -o cache_sim

./obj_dir/cache_sim > sim.log
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
